//--- common/nes_pkg.sv
// Shared widths, addresses and encodings for the NES host glue
// Every design file refers to these by scoped name

package nes_pkg;

	typedef logic [7:0]  byte_t;          // One ROM or header byte
	typedef logic [21:0] mem_addr_t;      // Cartridge memory byte address
	typedef logic [31:0] mapper_flags_t;  // Mapper flag word for the core
	typedef logic [7:0]  joy_t;           // Button byte in host order
	typedef logic [2:0]  size_code_t;     // Log2 of the page count, saturating

	// Loader phases
	typedef enum logic [2:0] {
		HEADER,
		PRG,
		CHR,
		DONE,
		FAIL
	} loader_state_t;

	// Memory map
	localparam mem_addr_t PRG_BASE = 22'h000000;
	localparam mem_addr_t CHR_BASE = 22'h200000;  // Bit 21 selects CHR

	localparam int PRG_PAGE_SHIFT = 14;  // 16 KB pages
	localparam int CHR_PAGE_SHIFT = 13;  // 8 KB pages

	localparam int HEADER_BYTES = 16;

	// "NES" followed by MS-DOS EOF
	localparam logic [31:0] INES_MAGIC = 32'h4E45531A;

	// Core held in reset this long once the download ends
	localparam logic [7:0] DL_RESET_CYCLES = 8'd255;

	// Console runs on one clock in four, memory writes go out in this slot
	localparam logic [1:0] MEM_SLOT = 2'd3;

endpackage

//--- rom_loader/ines_header_decode.sv
// Combinational decode of the sixteen iNES header bytes
// Gives header validity, PRG and CHR byte counts and the mapper flag word

`timescale 1ns/1ns

module ines_header_decode (
	input  nes_pkg::byte_t         hdr [nes_pkg::HEADER_BYTES],
	input  logic                   invert_mirroring,
	output logic                   header_ok,
	output nes_pkg::mem_addr_t     prg_bytes,
	output nes_pkg::mem_addr_t     chr_bytes,
	output nes_pkg::mapper_flags_t flags
);

	logic                 is_nes20;
	logic                 tail_used;
	logic                 is_dirty;
	nes_pkg::byte_t       mapper;
	nes_pkg::size_code_t  prg_code;
	nes_pkg::size_code_t  chr_code;

	// Smallest n with pages <= 2**n, stuck at 7 above that
	function automatic nes_pkg::size_code_t size_code(input nes_pkg::byte_t pages);
		nes_pkg::size_code_t code;
		code = 3'd7;
		for (int n = 6; n >= 0; n--) begin
			if ({1'b0, pages} <= (9'd1 << n))
				code = n[2:0];
		end
		return code;
	endfunction

	// Bytes 8 to 15 carry data only in a 2.0 header
	always_comb begin
		tail_used = 1'b0;
		for (int i = 8; i < nes_pkg::HEADER_BYTES; i++) begin
			if (hdr[i] != 8'h00)
				tail_used = 1'b1;
		end
	end

	assign is_nes20 = (hdr[7][3:2] == 2'b10);
	assign is_dirty = !is_nes20 && tail_used;  // Junk from old dump tools

	assign header_ok = ({hdr[0], hdr[1], hdr[2], hdr[3]} == nes_pkg::INES_MAGIC) &&
		!hdr[6][2];  // No trainer support

	assign mapper = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};

	assign prg_code = size_code(hdr[4]);
	assign chr_code = size_code(hdr[5]);

	assign prg_bytes = nes_pkg::mem_addr_t'(hdr[4]) << nes_pkg::PRG_PAGE_SHIFT;
	assign chr_bytes = nes_pkg::mem_addr_t'(hdr[5]) << nes_pkg::CHR_PAGE_SHIFT;

	assign flags = {
		15'd0,
		hdr[6][3],                     // Four-screen
		hdr[5] == 8'h00,               // CHR RAM
		hdr[6][0] ^ invert_mirroring,  // Mirroring
		chr_code,
		prg_code,
		mapper
	};

endmodule

//--- rom_loader/ines_loader.sv
// Takes the ROM image a byte per strobe and places it in cartridge memory
// Header bytes are kept for decode, PRG goes from PRG_BASE and CHR from CHR_BASE
// load_done holds until loader_clear, load_error marks a rejected header

`timescale 1ns/1ns

module ines_loader (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   loader_clear,
	input  logic                   dl_strobe,
	input  nes_pkg::byte_t         dl_data,
	input  logic                   invert_mirroring,
	output logic                   wr_req,
	output nes_pkg::mem_addr_t     wr_addr,
	output nes_pkg::byte_t         wr_data,
	output nes_pkg::mapper_flags_t mapper_flags,
	output logic                   load_done,
	output logic                   load_error
);

	nes_pkg::loader_state_t state;
	nes_pkg::byte_t         hdr      [nes_pkg::HEADER_BYTES];
	nes_pkg::byte_t         hdr_view [nes_pkg::HEADER_BYTES];
	logic [3:0]             ctr;
	logic                   hdr_last;
	nes_pkg::mem_addr_t     bytes_left;
	logic                   last_byte;
	logic                   header_ok;
	nes_pkg::mem_addr_t     prg_bytes;
	nes_pkg::mem_addr_t     chr_bytes;
	nes_pkg::mapper_flags_t flags;

	// Decode sees the byte arriving now, so the check lands with the 16th strobe
	always_comb begin
		hdr_view = hdr;
		if (state == nes_pkg::HEADER && dl_strobe)
			hdr_view[ctr] = dl_data;
	end

	ines_header_decode decode_i (
		.hdr              (hdr_view),
		.invert_mirroring (invert_mirroring),
		.header_ok        (header_ok),
		.prg_bytes        (prg_bytes),
		.chr_bytes        (chr_bytes),
		.flags            (flags)
	);

	assign hdr_last  = (ctr == 4'(nes_pkg::HEADER_BYTES - 1));
	assign last_byte = (bytes_left == 22'd1);

	assign wr_req  = dl_strobe && (state == nes_pkg::PRG || state == nes_pkg::CHR) &&
		(bytes_left != '0);
	assign wr_data = dl_data;

	assign load_done  = (state == nes_pkg::DONE) || (state == nes_pkg::FAIL);
	assign load_error = (state == nes_pkg::FAIL);

	always_ff @(posedge clk) begin
		if (state == nes_pkg::HEADER && dl_strobe)
			hdr[ctr] <= dl_data;
	end

	always_ff @(posedge clk) begin
		if (reset || loader_clear) begin
			state <= nes_pkg::HEADER;
			ctr   <= '0;
		end else begin
			case (state)
				nes_pkg::HEADER: if (dl_strobe) begin
					ctr <= ctr + 4'd1;
					if (hdr_last) begin
						if (!header_ok) begin
							state <= nes_pkg::FAIL;
						end else if (prg_bytes != '0) begin
							state      <= nes_pkg::PRG;
							wr_addr    <= nes_pkg::PRG_BASE;
							bytes_left <= prg_bytes;
						end else if (chr_bytes != '0) begin
							state      <= nes_pkg::CHR;
							wr_addr    <= nes_pkg::CHR_BASE;
							bytes_left <= chr_bytes;
						end else begin
							state        <= nes_pkg::DONE;
							mapper_flags <= flags;
						end
					end
				end
				nes_pkg::PRG: if (wr_req) begin
					wr_addr    <= wr_addr + 22'd1;
					bytes_left <= bytes_left - 22'd1;
					if (last_byte && chr_bytes != '0) begin
						state      <= nes_pkg::CHR;
						wr_addr    <= nes_pkg::CHR_BASE;
						bytes_left <= chr_bytes;
					end else if (last_byte) begin
						state        <= nes_pkg::DONE;  // CHR RAM cart
						mapper_flags <= flags;
					end
				end
				nes_pkg::CHR: if (wr_req) begin
					wr_addr    <= wr_addr + 22'd1;
					bytes_left <= bytes_left - 22'd1;
					if (last_byte) begin
						state        <= nes_pkg::DONE;
						mapper_flags <= flags;
					end
				end
				nes_pkg::DONE, nes_pkg::FAIL: ;  // Wait for loader_clear
				default: state <= nes_pkg::HEADER;
			endcase
		end
	end

endmodule

//--- hdl/reset_ctrl.sv
// Core reset generation
// Holds the core from power-up to the first download, during a download,
// for a fixed time after it, and while a load error or the button is active

`timescale 1ns/1ns

module reset_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic dl_active,
	input  logic reset_button,
	input  logic load_error,
	output logic nes_reset,
	output logic loader_clear
);

	logic       init_hold;  // Set until the first download begins
	logic [7:0] dl_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			init_hold <= 1'b1;
			dl_cnt    <= '0;
		end else begin
			if (dl_active) begin
				init_hold <= 1'b0;
				dl_cnt    <= nes_pkg::DL_RESET_CYCLES;  // Reloaded for the whole download
			end else if (dl_cnt != '0) begin
				dl_cnt <= dl_cnt - 8'd1;
			end
		end
	end

	assign nes_reset = init_hold || dl_active || (dl_cnt != '0) ||
		load_error || reset_button;

	// Loader goes back to waiting for a header once everything has settled
	assign loader_clear = !dl_active && (dl_cnt == '0);

endmodule

//--- hdl/joypad_port.sv
// Two NES controller ports
// Buttons are loaded in parallel on the strobe and shifted out
// on each falling edge of the port's clock, bit 0 first

`timescale 1ns/1ns

module joypad_port (
	input  logic          clk,
	input  logic          nes_reset,
	input  nes_pkg::joy_t joy_a,
	input  nes_pkg::joy_t joy_b,
	input  logic          joy_swap,
	input  logic          pad_strobe,
	input  logic [1:0]    pad_clock,
	output logic [1:0]    pad_data
);

	nes_pkg::joy_t port_bits [2];
	nes_pkg::joy_t load_val  [2];
	logic [1:0]    last_clock;

	// Host order to the order the console reads them
	function automatic nes_pkg::joy_t nes_order(input nes_pkg::joy_t b);
		return {b[0], b[1], b[2], b[3], b[7], b[6], b[5], b[4]};
	endfunction

	assign load_val[0] = joy_swap ? nes_order(joy_b) : nes_order(joy_a);
	assign load_val[1] = joy_swap ? nes_order(joy_a) : nes_order(joy_b);

	always_ff @(posedge clk) begin
		if (nes_reset) begin
			last_clock <= '0;
			for (int p = 0; p < 2; p++)
				port_bits[p] <= '0;  // Nothing pressed while the core is held
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (pad_strobe)
					port_bits[p] <= load_val[p];
				if (last_clock[p] && !pad_clock[p])
					port_bits[p] <= {1'b0, port_bits[p][7:1]};  // Empty port reads zero
			end
			last_clock <= pad_clock;
		end
	end

	assign pad_data = {port_bits[1][0], port_bits[0][0]};

endmodule

//--- hdl/mem_slot_writer.sv
// Console clock-enable and loader write scheduling
// A loader write is held and issued in the cycle after the memory slot,
// when the core is not using the memory

`timescale 1ns/1ns

module mem_slot_writer (
	input  logic               clk,
	input  logic               reset,
	input  logic               wr_req,
	input  nes_pkg::mem_addr_t wr_addr,
	input  nes_pkg::byte_t     wr_data,
	output logic               run_nes,
	output logic               mem_we,
	output nes_pkg::mem_addr_t mem_addr,
	output nes_pkg::byte_t     mem_data
);

	logic [1:0]         slot_cnt;
	logic               pending;  // One write waiting for its slot
	nes_pkg::mem_addr_t hold_addr;
	nes_pkg::byte_t     hold_data;

	assign run_nes = (slot_cnt == nes_pkg::MEM_SLOT);

	always_ff @(posedge clk) begin
		if (reset) begin
			slot_cnt <= '0;
			pending  <= 1'b0;
			mem_we   <= 1'b0;
		end else begin
			slot_cnt <= slot_cnt + 2'd1;
			pending  <= wr_req || (pending && !run_nes);
			mem_we   <= run_nes && pending;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_req) begin
			hold_addr <= wr_addr;
			hold_data <= wr_data;
		end
		if (run_nes && pending) begin
			mem_addr <= hold_addr;
			mem_data <= hold_data;
		end
	end

endmodule

//--- hdl/nes_host.sv
// Host-side glue for the NES core
// Cartridge download, core reset, memory write slot and controller ports

`timescale 1ns/1ns

module nes_host (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic                   dl_strobe,
	input  nes_pkg::byte_t         dl_data,
	input  logic                   invert_mirroring,
	input  logic                   reset_button,
	input  nes_pkg::joy_t          joy_a,
	input  nes_pkg::joy_t          joy_b,
	input  logic                   joy_swap,
	input  logic                   pad_strobe,
	input  logic [1:0]             pad_clock,
	output logic                   nes_reset,
	output logic                   run_nes,
	output logic                   mem_we,
	output nes_pkg::mem_addr_t     mem_addr,
	output nes_pkg::byte_t         mem_data,
	output nes_pkg::mapper_flags_t mapper_flags,
	output logic                   load_done,
	output logic                   load_error,
	output logic [1:0]             pad_data
);

	logic               loader_clear;
	logic               wr_req;
	nes_pkg::mem_addr_t wr_addr;
	nes_pkg::byte_t     wr_data;

	reset_ctrl reset_ctrl_i (
		.clk          (clk),
		.reset        (reset),
		.dl_active    (dl_active),
		.reset_button (reset_button),
		.load_error   (load_error),
		.nes_reset    (nes_reset),
		.loader_clear (loader_clear)
	);

	ines_loader loader_i (
		.clk              (clk),
		.reset            (reset),
		.loader_clear     (loader_clear),
		.dl_strobe        (dl_strobe),
		.dl_data          (dl_data),
		.invert_mirroring (invert_mirroring),
		.wr_req           (wr_req),
		.wr_addr          (wr_addr),
		.wr_data          (wr_data),
		.mapper_flags     (mapper_flags),
		.load_done        (load_done),
		.load_error       (load_error)
	);

	mem_slot_writer slot_i (
		.clk      (clk),
		.reset    (reset),
		.wr_req   (wr_req),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.run_nes  (run_nes),
		.mem_we   (mem_we),
		.mem_addr (mem_addr),
		.mem_data (mem_data)
	);

	joypad_port joypad_i (
		.clk        (clk),
		.nes_reset  (nes_reset),
		.joy_a      (joy_a),
		.joy_b      (joy_b),
		.joy_swap   (joy_swap),
		.pad_strobe (pad_strobe),
		.pad_clock  (pad_clock),
		.pad_data   (pad_data)
	);

endmodule

//--- test/tb_nes_host.sv
// Testbench for the NES host glue
// Downloads a good, a dirty and a bad ROM image, checks every memory write
// against a queue model, then the post-download reset and both controller ports

`timescale 1ns/1ns

module tb_nes_host;

	localparam int BYTE_CYCLES = 6;
	// Header plus data of the three images
	localparam longint TEST_BYTES = (16 + 16384 + 8192) + (16 + 32768) + 16;
	localparam longint WATCHDOG_NS = 2 * TEST_BYTES * BYTE_CYCLES * 8;

	logic                   clk;
	logic                   reset;
	logic                   dl_active;
	logic                   dl_strobe;
	nes_pkg::byte_t         dl_data;
	logic                   invert_mirroring;
	logic                   reset_button;
	nes_pkg::joy_t          joy_a;
	nes_pkg::joy_t          joy_b;
	logic                   joy_swap;
	logic                   pad_strobe;
	logic [1:0]             pad_clock;
	logic                   nes_reset;
	logic                   run_nes;
	logic                   mem_we;
	nes_pkg::mem_addr_t     mem_addr;
	nes_pkg::byte_t         mem_data;
	nes_pkg::mapper_flags_t mapper_flags;
	logic                   load_done;
	logic                   load_error;
	logic [1:0]             pad_data;

	nes_pkg::mem_addr_t exp_addr [$];  // Expected writes, oldest first
	nes_pkg::byte_t     exp_data [$];
	nes_pkg::byte_t     header   [$];
	int                 writes_seen;
	int                 cycles_run;  // Clock cycles since reset
	logic               run_prev;    // run_nes one cycle back

	nes_host dut_i (.*);

	always #4 clk = ~clk;

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	// Smallest n with pages <= 2**n, at most 7
	function automatic logic [2:0] size_code_of(input nes_pkg::byte_t pages);
		int n;
		n = 0;
		while (n < 7 && (1 << n) < int'(pages))
			n++;
		return 3'(n);
	endfunction

	function automatic nes_pkg::mapper_flags_t expected_flags(input logic inv);
		nes_pkg::mapper_flags_t f;
		logic                   dirty;
		f = '0;
		dirty = 1'b0;
		for (int i = 8; i < 16; i++) begin
			if (header[i] != 8'h00 && header[7][3:2] != 2'b10)
				dirty = 1'b1;
		end
		f[3:0]   = header[6][7:4];
		f[7:4]   = dirty ? 4'h0 : header[7][7:4];
		f[10:8]  = size_code_of(header[4]);
		f[13:11] = size_code_of(header[5]);
		f[14]    = header[6][0] ^ inv;
		f[15]    = (header[5] == 8'h00);
		f[16]    = header[6][3];
		return f;
	endfunction

	// Host bits for console bits 7 down to 0
	function automatic nes_pkg::joy_t console_order(input nes_pkg::joy_t host);
		int            src [$];
		nes_pkg::joy_t r;
		nes_pkg::joy_t sh;
		src = '{0, 1, 2, 3, 7, 6, 5, 4};
		r = '0;
		while (src.size() > 0) begin
			sh = host >> src.pop_front();
			r = {r[6:0], sh[0]};
		end
		return r;
	endfunction

	task automatic make_header(input logic [31:0] magic, input nes_pkg::byte_t prg,
		input nes_pkg::byte_t chr, input nes_pkg::byte_t b6, input nes_pkg::byte_t b7,
		input nes_pkg::byte_t b12);
		header.delete();
		for (int i = 0; i < 16; i++)
			header.push_back(8'h00);
		header[0]  = magic[31:24];
		header[1]  = magic[23:16];
		header[2]  = magic[15:8];
		header[3]  = magic[7:0];
		header[4]  = prg;
		header[5]  = chr;
		header[6]  = b6;
		header[7]  = b7;
		header[12] = b12;
	endtask

	task automatic send_byte(input nes_pkg::byte_t b);
		@(negedge clk);
		dl_strobe = 1'b1;
		dl_data   = b;
		@(negedge clk);
		dl_strobe = 1'b0;
		repeat (BYTE_CYCLES - 2) @(negedge clk);
	endtask

	task automatic send_data(input nes_pkg::mem_addr_t base, input int len);
		nes_pkg::byte_t b;
		for (int i = 0; i < len; i++) begin
			b = 8'($urandom);
			exp_addr.push_back(base + 22'(i));
			exp_data.push_back(b);
			send_byte(b);
		end
	endtask

	task automatic load_image(input logic expect_error);
		int n;
		@(negedge clk);
		assert (!load_done)
		else abort_run($sformatf("[ERROR] %0t: load_done set before download", $time));
		dl_active = 1'b1;
		foreach (header[i])
			send_byte(header[i]);
		if (!expect_error) begin
			assert (!load_done && !load_error)
			else abort_run($sformatf("[ERROR] %0t: load ended after the header", $time));
			send_data(nes_pkg::PRG_BASE, int'(header[4]) << 14);
			send_data(nes_pkg::CHR_BASE, int'(header[5]) << 13);
		end
		n = 0;
		while (!load_done && n < 16) begin
			@(negedge clk);
			n++;
		end
		assert (load_done) else abort_run("load_done did not rise after the last byte");
		assert (load_error == expect_error)
		else abort_run($sformatf("[ERROR] %0t: load_error is %b", $time, load_error));
		repeat (8) @(negedge clk);
		assert (exp_addr.size() == 0)
		else abort_run($sformatf("%0d bytes never reached memory", exp_addr.size()));
	endtask

	// Counts the cycles the core stays in reset once dl_active falls
	task automatic end_download(input logic after_error);
		int held;
		@(negedge clk);
		dl_active = 1'b0;
		#1;
		held = 0;
		while ((nes_reset || load_error) && held < 1000) begin
			assert (nes_reset)
			else abort_run($sformatf("[ERROR] %0t: core left reset during error", $time));
			held++;
			@(negedge clk);
		end
		assert (held < 1000) else abort_run("core reset never released after the download");
		if (after_error) begin
			assert (held >= 255)
			else abort_run($sformatf("[ERROR] %0t: error reset only %0d", $time, held));
		end else begin
			assert (held == 255)
			else abort_run($sformatf("[ERROR] %0t: reset held %0d cycles", $time, held));
		end
		repeat (2) @(negedge clk);
	endtask

	task automatic check_pads(input logic swap);
		nes_pkg::joy_t exp0;
		nes_pkg::joy_t exp1;
		@(negedge clk);
		assert (!nes_reset) else abort_run("core still in reset at the controller test");
		joy_a      = 8'($urandom);
		joy_b      = 8'($urandom);
		joy_swap   = swap;
		pad_strobe = 1'b1;
		@(negedge clk);
		pad_strobe = 1'b0;
		exp0 = console_order(swap ? joy_b : joy_a);
		exp1 = console_order(swap ? joy_a : joy_b);
		for (int k = 0; k < 10; k++) begin  // Eight buttons, then two empty reads
			assert (pad_data == {exp1[0], exp0[0]})
			else abort_run($sformatf("[ERROR] %0t: pad bit %0d is %b, expected %b",
				$time, k, pad_data, {exp1[0], exp0[0]}));
			pad_clock = 2'b11;
			@(negedge clk);
			pad_clock = 2'b00;
			@(negedge clk);
			exp0 = exp0 >> 1;
			exp1 = exp1 >> 1;
		end
	endtask

	// The console slot comes every fourth cycle counted from reset
	always @(posedge clk) begin
		if (reset)
			cycles_run <= 0;
		else
			cycles_run <= cycles_run + 1;
	end

	// Slot enable, write timing and each mem_we against the oldest queued write
	always @(negedge clk) begin : write_check
		nes_pkg::mem_addr_t a;
		nes_pkg::byte_t     d;
		assert (run_nes == (cycles_run % 4 == 3))
		else abort_run($sformatf("[ERROR] %0t: run_nes is %b in cycle %0d",
			$time, run_nes, cycles_run));
		assert (!mem_we || run_prev)
		else abort_run($sformatf("[ERROR] %0t: mem_we not right after run_nes", $time));
		run_prev = run_nes;
		if (mem_we) begin
			assert (exp_addr.size() != 0)
			else abort_run($sformatf("[ERROR] %0t: stray write to %h", $time, mem_addr));
			a = exp_addr.pop_front();
			d = exp_data.pop_front();
			assert (mem_addr == a && mem_data == d)
			else abort_run($sformatf("[ERROR] %0t: write %0d got %h:%h, expected %h:%h",
				$time, writes_seen, mem_addr, mem_data, a, d));
			writes_seen++;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run("Timeout: the run went past the time the tests need");
	end

	initial begin
		void'($urandom(53));
		clk              = 1'b0;
		reset            = 1'b1;
		dl_active        = 1'b0;
		dl_strobe        = 1'b0;
		dl_data          = 8'h00;
		invert_mirroring = 1'b0;
		reset_button     = 1'b0;
		joy_a            = 8'h00;
		joy_b            = 8'h00;
		joy_swap         = 1'b0;
		pad_strobe       = 1'b0;
		pad_clock        = 2'b00;
		writes_seen      = 0;
		run_prev         = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b0;

		assert (!mem_we && !load_done && !load_error && pad_data == 2'b00 && nes_reset)
		else abort_run($sformatf("[ERROR] %0t: outputs wrong after reset", $time));
		repeat (20) begin
			@(negedge clk);
			assert (nes_reset)
			else abort_run($sformatf("[ERROR] %0t: core out of reset too early", $time));
		end

		// Mapper 4, one PRG page, one CHR page
		invert_mirroring = 1'b1;
		make_header(32'h4E45531A, 8'd1, 8'd1, 8'h40, 8'h00, 8'h00);
		load_image(1'b0);
		assert (mapper_flags == expected_flags(1'b1))
		else abort_run($sformatf("[ERROR] %0t: mapper_flags %h", $time, mapper_flags));
		end_download(1'b0);
		check_pads(1'b0);
		check_pads(1'b1);

		// Junk in byte 12, CHR RAM, four-screen
		invert_mirroring = 1'b0;
		make_header(32'h4E45531A, 8'd2, 8'd0, 8'h29, 8'h10, 8'h55);
		load_image(1'b0);
		assert (mapper_flags == expected_flags(1'b0) && mapper_flags[7:4] == 4'h0 &&
			mapper_flags[15])
		else abort_run($sformatf("[ERROR] %0t: dirty flags %h", $time, mapper_flags));
		end_download(1'b0);

		make_header(32'h4E455300, 8'd1, 8'd1, 8'h00, 8'h00, 8'h00);
		load_image(1'b1);
		end_download(1'b1);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- src.f
common/nes_pkg.sv
rom_loader/ines_header_decode.sv
rom_loader/ines_loader.sv
hdl/reset_ctrl.sv
hdl/joypad_port.sv
hdl/mem_slot_writer.sv
hdl/nes_host.sv
test/tb_nes_host.sv

//--- Makefile
# Lint and simulate the NES host glue with Verilator
# make sim succeeds only when the log holds the pass line

TB_TOP := tb_nes_host

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
